// File: cpu3.f
+incdir+hw
hw/cpu3_pkg.sv
hw/reg_file.sv
hw/fetch_decode.sv
hw/control_decode.sv
hw/execute.sv
hw/mem_writeback.sv
hw/cpu3_top.sv
bench/cpu3_tb.sv

// File: bench/cpu3_tb.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module cpu3_tb;

    localparam int CLK_NS      = 20;
    localparam int ALU_PAIRS   = 20;
    localparam int FWD_ROUNDS  = 4;
    localparam int BR_TRIALS   = 4;
    localparam int CSR_TRIALS  = 4;
    localparam int NUM_TESTS   = ALU_PAIRS * 10 + FWD_ROUNDS + 16 + 6 * BR_TRIALS + CSR_TRIALS;
    // Longest program plus reset and run time stays below this
    localparam int TEST_CYCLES = 80;
    localparam int RUN_CYCLES  = 60;
    localparam int MARGIN      = 2000;

    logic                                clk;
    logic                                rst;
    logic                                prog_we;
    logic [$clog2(`CPU3_IMEM_WORDS)-1:0] prog_addr;
    logic [31:0]                         prog_data;
    logic [31:0]                         tohost;

    // Program under construction
    logic [31:0] prog [$];
    // Handoff from stimulus to the comparing process
    string       cur_name;
    logic [31:0] cur_exp;
    logic        check_req;
    int          checks;
    int          errors;

    cpu3_top dut (
        .clk(clk), .rst(rst),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .tohost(tohost)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `CPU3_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `CPU3_OP_STORE};
    endfunction

    // Byte offset, bit 0 dropped by the format
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `CPU3_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // src is rs1 for CSRRW, the 5-bit immediate for CSRRWI
    function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [4:0] src);
        return {`CPU3_CSR_TOHOST, src, f3, 5'd0, `CPU3_OP_SYSTEM};
    endfunction

    // Op index 0..9: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic logic [31:0] enc_alu(input int op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        case (op)
            0, 1:    f3 = `CPU3_F3_ADD;
            2:       f3 = `CPU3_F3_SLL;
            3:       f3 = `CPU3_F3_SLT;
            4:       f3 = `CPU3_F3_SLTU;
            5:       f3 = `CPU3_F3_XOR;
            6, 7:    f3 = `CPU3_F3_SR;
            8:       f3 = `CPU3_F3_OR;
            default: f3 = `CPU3_F3_AND;
        endcase
        f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
        return enc_r(f7, rs2, rs1, f3, rd);
    endfunction

    function automatic string alu_name(input int op);
        string names [10] = '{"add", "sub", "sll", "slt", "sltu",
                              "xor", "srl", "sra", "or", "and"};
        return names[op];
    endfunction

    // Reference model, straight from the ISA rules
    function automatic logic [31:0] ref_alu(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [31:0] word,
                                             input int ofs);
        logic [7:0]  by;
        logic [15:0] hw;
        by = word[8*ofs +: 8];
        hw = (ofs >= 2) ? word[31:16] : word[15:0];
        case (f3)
            `CPU3_F3_B:  return {{24{by[7]}}, by};
            `CPU3_F3_BU: return {24'd0, by};
            `CPU3_F3_H:  return {{16{hw[15]}}, hw};
            `CPU3_F3_HU: return {16'd0, hw};
            default:     return word;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            `CPU3_F3_BEQ:  return a == b;
            `CPU3_F3_BNE:  return a != b;
            `CPU3_F3_BLT:  return $signed(a) < $signed(b);
            `CPU3_F3_BGE:  return $signed(a) >= $signed(b);
            `CPU3_F3_BLTU: return a < b;
            default:       return a >= b;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // LUI then ADDI; the +800 absorbs the sign of the low 12 bits
    task automatic add_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(enc_u(upper[31:12], rd, `CPU3_OP_LUI));
        prog.push_back(enc_i(value[11:0], rd, `CPU3_F3_ADD, rd, `CPU3_OP_IMM));
    endtask

    // Publish result, then park on a self-branch
    task automatic finish_prog(input logic [4:0] src);
        prog.push_back(enc_csr(`CPU3_F3_CSRRW, src));
        prog.push_back(enc_b(13'd0, 5'd0, 5'd0, `CPU3_F3_BEQ));
    endtask

    // Load while in reset, hold reset 4 more cycles, run, hand over for compare
    task automatic run_test(input string name, input logic [31:0] expected);
        @(posedge clk);
        rst <= 1'b1;
        foreach (prog[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i;
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        cur_name = name;
        cur_exp  = expected;
        check_req <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
    endtask

    // Sampled mid-cycle, well away from the edges
    always @(negedge clk) begin
        if (check_req) begin
            compare(cur_name, cur_exp, tohost);
        end
    end

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        for (int p = 0; p < ALU_PAIRS; p++) begin
            a = $urandom();
            b = $urandom();
            for (int op = 0; op < 10; op++) begin
                prog.delete();
                add_const(5'd1, a);
                add_const(5'd2, b);
                prog.push_back(enc_alu(op, 5'd3, 5'd1, 5'd2));
                finish_prog(5'd3);
                run_test($sformatf("alu %s pair %0d", alu_name(op), p), ref_alu(op, a, b));
            end
        end
    endtask

    // Each ADD uses the previous one (MW to X) and the one before (MW to FD)
    task automatic test_forwarding();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s3;
        logic [31:0] s4;
        logic [31:0] s5;
        logic [31:0] s6;
        for (int r = 0; r < FWD_ROUNDS; r++) begin
            a = $urandom();
            b = $urandom();
            prog.delete();
            add_const(5'd1, a);
            add_const(5'd2, b);
            prog.push_back(enc_alu(0, 5'd3, 5'd1, 5'd2));
            prog.push_back(enc_alu(0, 5'd4, 5'd3, 5'd1));
            prog.push_back(enc_alu(0, 5'd5, 5'd4, 5'd3));
            prog.push_back(enc_alu(0, 5'd6, 5'd5, 5'd4));
            finish_prog(5'd6);
            s3 = ref_alu(0, a, b);
            s4 = ref_alu(0, s3, a);
            s5 = ref_alu(0, s4, s3);
            s6 = ref_alu(0, s5, s4);
            run_test($sformatf("forward chain %0d", r), s6);
        end
    endtask

    // SW a word at 0x100, SB over one lane, load it back
    task automatic test_load_store();
        logic [31:0] word;
        logic [31:0] merged;
        logic [7:0]  bval;
        logic [2:0]  f3;
        logic [11:0] sb_addr;
        logic [11:0] ld_addr;
        int          lofs;
        string       kind;
        for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 4; k++) begin
                word = $urandom();
                bval = $urandom();
                case (k)
                    0:       f3 = `CPU3_F3_B;
                    1:       f3 = `CPU3_F3_BU;
                    2:       f3 = `CPU3_F3_H;
                    default: f3 = `CPU3_F3_HU;
                endcase
                kind = (k == 0) ? "lb" : (k == 1) ? "lbu" : (k == 2) ? "lh" : "lhu";
                // Halfwords stay aligned, on the half holding the new byte
                lofs    = (k < 2) ? off : (off & 2);
                sb_addr = 12'h100 + off;
                ld_addr = 12'h100 + lofs;
                prog.delete();
                add_const(5'd5, word);
                prog.push_back(enc_i({{4{bval[7]}}, bval}, 5'd0, `CPU3_F3_ADD, 5'd6,
                                     `CPU3_OP_IMM));
                prog.push_back(enc_s(12'h100, 5'd5, 5'd0, `CPU3_F3_W));
                prog.push_back(enc_s(sb_addr, 5'd6, 5'd0, `CPU3_F3_B));
                prog.push_back(enc_i(ld_addr, 5'd0, f3, 5'd7, `CPU3_OP_LOAD));
                finish_prog(5'd7);
                merged = (word & ~(32'hFF << (8 * off))) | ({24'd0, bval} << (8 * off));
                run_test($sformatf("%s sb offset %0d", kind, off), ref_load(f3, merged, lofs));
            end
        end
    endtask

    // Marker 5 survives a taken branch, 9 means the skip did not happen
    task automatic test_branches();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        string       kind;
        for (int k = 0; k < 6; k++) begin
            case (k)
                0:       f3 = `CPU3_F3_BEQ;
                1:       f3 = `CPU3_F3_BNE;
                2:       f3 = `CPU3_F3_BLT;
                3:       f3 = `CPU3_F3_BGE;
                4:       f3 = `CPU3_F3_BLTU;
                default: f3 = `CPU3_F3_BGEU;
            endcase
            kind = (k == 0) ? "beq" : (k == 1) ? "bne" : (k == 2) ? "blt" :
                   (k == 3) ? "bge" : (k == 4) ? "bltu" : "bgeu";
            for (int t = 0; t < BR_TRIALS; t++) begin
                a = $urandom();
                b = $urandom();
                // Equal operands, then a sign flip where signed and unsigned disagree
                if (t == 0) begin
                    b = a;
                end else if (t == 1) begin
                    b = a ^ 32'h8000_0000;
                end
                prog.delete();
                add_const(5'd1, a);
                add_const(5'd2, b);
                prog.push_back(enc_i(12'd5, 5'd0, `CPU3_F3_ADD, 5'd3, `CPU3_OP_IMM));
                prog.push_back(enc_b(13'd8, 5'd2, 5'd1, f3));
                prog.push_back(enc_i(12'd9, 5'd0, `CPU3_F3_ADD, 5'd3, `CPU3_OP_IMM));
                finish_prog(5'd3);
                run_test($sformatf("%s trial %0d", kind, t),
                         ref_branch(f3, a, b) ? 32'd5 : 32'd9);
            end
        end
    endtask

    task automatic test_csrrwi();
        int unsigned r;
        logic [4:0]  uimm;
        for (int t = 0; t < CSR_TRIALS; t++) begin
            // Nonzero so the reset value of tohost cannot match
            r    = 1 + $urandom() % 31;
            uimm = r[4:0];
            prog.delete();
            prog.push_back(enc_csr(`CPU3_F3_CSRRWI, uimm));
            prog.push_back(enc_b(13'd0, 5'd0, 5'd0, `CPU3_F3_BEQ));
            run_test($sformatf("csrrwi trial %0d", t), {27'd0, uimm});
        end
    endtask

    initial begin
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        check_req = 1'b0;
        checks    = 0;
        errors    = 0;
        void'($urandom(54665));
        test_alu();
        test_forwarding();
        test_load_store();
        test_branches();
        test_csrrwi();
        @(posedge clk);
        if (checks != NUM_TESTS) begin
            errors++;
            $display("Only %0d of %0d expected checks were run", checks, NUM_TESTS);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, sized from the test count
    initial begin
        #((NUM_TESTS * TEST_CYCLES + MARGIN) * CLK_NS);
        $display("Watchdog expired: the run did not finish and the core appears to hang");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: hw/cpu3_top.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module cpu3_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                prog_we,
    input  logic [$clog2(`CPU3_IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                         prog_data,
    output logic [31:0]                         tohost
);
    import cpu3_pkg::*;

    // Stage registers and control
    fd_x_t       fd_x;
    x_mw_t       x_mw;
    ctrl_t       x_ctrl;
    ctrl_t       mw_ctrl;
    inst_u       x_inst;
    inst_u       mw_inst;
    wb_t         wb;

    // Branch resolution
    logic        br_eq;
    logic        br_lt;
    logic        br_ltu;
    logic        branch_taken;
    logic [31:0] branch_target;

    // Register file ports
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [31:0] rd1;
    logic [31:0] rd2;

    // Data memory request, issued from X
    logic        store_en;
    logic [3:0]  store_mask;
    logic [31:0] store_data;
    logic [31:0] mem_addr;

    fetch_decode u_fd (
        .clk(clk), .rst(rst),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .wb(wb), .rd1(rd1), .rd2(rd2),
        .ra1(ra1), .ra2(ra2), .fd_x(fd_x)
    );

    control_decode u_ctrl (
        .clk(clk), .rst(rst),
        .fd_x(fd_x), .x_inst(x_inst), .mw_inst(mw_inst),
        .br_eq(br_eq), .br_lt(br_lt), .br_ltu(br_ltu),
        .x_ctrl(x_ctrl), .mw_ctrl(mw_ctrl), .branch_taken(branch_taken)
    );

    execute u_ex (
        .clk(clk), .rst(rst),
        .fd_x(fd_x), .x_ctrl(x_ctrl), .wb(wb),
        .br_eq(br_eq), .br_lt(br_lt), .br_ltu(br_ltu),
        .branch_target(branch_target), .x_inst(x_inst),
        .store_en(store_en), .store_mask(store_mask), .store_data(store_data),
        .mem_addr(mem_addr), .x_mw(x_mw), .tohost(tohost)
    );

    mem_writeback u_mw (
        .clk(clk), .rst(rst),
        .x_mw(x_mw), .mw_ctrl(mw_ctrl),
        .store_en(store_en), .store_mask(store_mask), .store_data(store_data),
        .mem_addr(mem_addr), .mw_inst(mw_inst), .wb(wb)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst),
        .ra1(ra1), .ra2(ra2), .wb(wb),
        .rd1(rd1), .rd2(rd2)
    );

endmodule

// File: hw/mem_writeback.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module mem_writeback (
    input  logic            clk,
    input  logic            rst,
    input  cpu3_pkg::x_mw_t x_mw,
    input  cpu3_pkg::ctrl_t mw_ctrl,
    input  logic            store_en,
    input  logic [3:0]      store_mask,
    input  logic [31:0]     store_data,
    input  logic [31:0]     mem_addr,
    output cpu3_pkg::inst_u mw_inst,
    output cpu3_pkg::wb_t   wb
);
    localparam int DMEM_AW = $clog2(`CPU3_DMEM_WORDS);

    logic [31:0]        dmem [`CPU3_DMEM_WORDS];
    logic [31:0]        dmem_q;
    logic [DMEM_AW-1:0] word_idx;
    logic [7:0]         byte_lane;
    logic [15:0]        half_lane;
    logic [31:0]        load_val;

    // Address comes from X, data returns in MW
    assign word_idx = mem_addr[DMEM_AW+1:2];

    // Byte-write data memory
    always_ff @(posedge clk) begin
        if (store_en && !rst) begin
            for (int b = 0; b < 4; b++) begin
                if (store_mask[b]) begin
                    dmem[word_idx][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
        dmem_q <= dmem[word_idx];
    end

    // Lane pick uses the address saved in the X-to-MW register
    assign byte_lane = dmem_q[{x_mw.alu[1:0], 3'b000} +: 8];
    assign half_lane = x_mw.alu[1] ? dmem_q[31:16] : dmem_q[15:0];

    // Load extension
    always_comb begin
        case (x_mw.inst.i.funct3)
            `CPU3_F3_B:  load_val = {{24{byte_lane[7]}}, byte_lane};
            `CPU3_F3_BU: load_val = {24'b0, byte_lane};
            `CPU3_F3_H:  load_val = {{16{half_lane[15]}}, half_lane};
            `CPU3_F3_HU: load_val = {16'b0, half_lane};
            default:     load_val = dmem_q;
        endcase
    end

    assign mw_inst = x_mw.inst;

    // Writeback select
    // x0 writes are dropped here so no bypass ever matches x0
    assign wb.wen  = mw_ctrl.reg_wen && x_mw.inst.r.rd != 5'd0;
    assign wb.rd   = x_mw.inst.r.rd;
    assign wb.data = mw_ctrl.wb_sel_mem ? load_val : x_mw.alu;

endmodule

// File: hw/execute.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module execute (
    input  logic            clk,
    input  logic            rst,
    input  cpu3_pkg::fd_x_t fd_x,
    input  cpu3_pkg::ctrl_t x_ctrl,
    input  cpu3_pkg::wb_t   wb,
    output logic            br_eq,
    output logic            br_lt,
    output logic            br_ltu,
    output logic [31:0]     branch_target,
    output cpu3_pkg::inst_u x_inst,
    output logic            store_en,
    output logic [3:0]      store_mask,
    output logic [31:0]     store_data,
    output logic [31:0]     mem_addr,
    output cpu3_pkg::x_mw_t x_mw,
    output logic [31:0]     tohost
);
    import cpu3_pkg::*;

    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu;
    logic [4:0]  shamt;

    assign x_inst = fd_x.inst;

    // MW result is newer than what FD read
    assign rs1 = (wb.wen && wb.rd == fd_x.inst.r.rs1) ? wb.data : fd_x.rs1_val;
    assign rs2 = (wb.wen && wb.rd == fd_x.inst.r.rs2) ? wb.data : fd_x.rs2_val;

    // Branch compare
    assign br_eq         = rs1 == rs2;
    assign br_lt         = $signed(rs1) < $signed(rs2);
    assign br_ltu        = rs1 < rs2;
    assign branch_target = fd_x.pc + fd_x.imm;

    // ALU operand select
    assign op_a  = x_ctrl.a_sel_pc ? fd_x.pc : rs1;
    assign op_b  = x_ctrl.b_sel_imm ? fd_x.imm : rs2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (x_ctrl.alu_op)
            ALU_ADD:    alu = op_a + op_b;
            ALU_SUB:    alu = op_a - op_b;
            ALU_SLL:    alu = op_a << shamt;
            ALU_SLT:    alu = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu = {31'b0, op_a < op_b};
            ALU_XOR:    alu = op_a ^ op_b;
            ALU_SRL:    alu = op_a >> shamt;
            ALU_SRA:    alu = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu = op_a | op_b;
            ALU_AND:    alu = op_a & op_b;
            // LUI passes the immediate straight through
            ALU_COPY_B: alu = op_b;
            default:    alu = '0;
        endcase
    end

    assign mem_addr = alu;
    assign store_en = x_ctrl.mem_write;

    // Store lanes from width and low address bits
    always_comb begin
        case (fd_x.inst.s.funct3)
            `CPU3_F3_B: begin
                store_mask = 4'b0001 << alu[1:0];
                store_data = rs2 << {alu[1:0], 3'b000};
            end
            `CPU3_F3_H: begin
                store_mask = 4'b0011 << {alu[1], 1'b0};
                store_data = rs2 << {alu[1], 4'b0000};
            end
            default: begin
                store_mask = 4'b1111;
                store_data = rs2;
            end
        endcase
    end

    // tohost CSR
    // CSRRWI takes the rs1 field as a 5-bit immediate
    always_ff @(posedge clk) begin
        if (rst) begin
            tohost <= '0;
        end else if (x_ctrl.csr_write) begin
            tohost <= (fd_x.inst.i.funct3 == `CPU3_F3_CSRRWI) ?
                      {27'b0, fd_x.inst.i.rs1} : rs1;
        end
    end

    // X-to-MW register
    always_ff @(posedge clk) begin
        if (rst) begin
            x_mw.inst <= `CPU3_NOP;
        end else begin
            x_mw.inst <= fd_x.inst;
        end
        x_mw.alu <= alu;
    end

    // Halfword accesses never straddle a word, even after forwarding
    assert property (@(posedge clk) disable iff (rst)
        (store_en || x_ctrl.mem_read) && fd_x.inst.s.funct3[1:0] == 2'b01
        |-> !mem_addr[0]);

endmodule

// File: hw/control_decode.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module control_decode (
    input  logic            clk,
    input  logic            rst,
    input  cpu3_pkg::fd_x_t fd_x,
    input  cpu3_pkg::inst_u x_inst,
    input  cpu3_pkg::inst_u mw_inst,
    input  logic            br_eq,
    input  logic            br_lt,
    input  logic            br_ltu,
    output cpu3_pkg::ctrl_t x_ctrl,
    output cpu3_pkg::ctrl_t mw_ctrl,
    output logic            branch_taken
);
    import cpu3_pkg::*;

    logic take;

    // funct7[5] picks SUB for R-type only, SRA for both forms
    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt,
                                           input logic is_imm);
        alu_op_e op;
        case (funct3)
            `CPU3_F3_ADD:  op = (alt && !is_imm) ? ALU_SUB : ALU_ADD;
            `CPU3_F3_SLL:  op = ALU_SLL;
            `CPU3_F3_SLT:  op = ALU_SLT;
            `CPU3_F3_SLTU: op = ALU_SLTU;
            `CPU3_F3_XOR:  op = ALU_XOR;
            `CPU3_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `CPU3_F3_OR:   op = ALU_OR;
            default:       op = ALU_AND;
        endcase
        return op;
    endfunction

    // Shared by both stages
    function automatic ctrl_t decode(input inst_u inst);
        ctrl_t c;
        c = '0;
        c.alu_op = ALU_ADD;
        case (inst.r.opcode)
            `CPU3_OP_LUI: begin
                c.b_sel_imm = 1'b1;
                c.alu_op    = ALU_COPY_B;
                c.reg_wen   = 1'b1;
            end
            `CPU3_OP_AUIPC: begin
                c.a_sel_pc  = 1'b1;
                c.b_sel_imm = 1'b1;
                c.reg_wen   = 1'b1;
            end
            `CPU3_OP_IMM: begin
                c.b_sel_imm = 1'b1;
                c.alu_op    = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b1);
                c.reg_wen   = 1'b1;
            end
            `CPU3_OP_REG: begin
                c.alu_op  = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b0);
                c.reg_wen = 1'b1;
            end
            // Address is rs1 + imm through the ALU
            `CPU3_OP_LOAD: begin
                c.b_sel_imm  = 1'b1;
                c.mem_read   = 1'b1;
                c.reg_wen    = 1'b1;
                c.wb_sel_mem = 1'b1;
            end
            `CPU3_OP_STORE: begin
                c.b_sel_imm = 1'b1;
                c.mem_write = 1'b1;
            end
            // Only tohost exists and other CSRs are ignored
            `CPU3_OP_SYSTEM: begin
                c.csr_write = (inst.i.funct3 == `CPU3_F3_CSRRW ||
                               inst.i.funct3 == `CPU3_F3_CSRRWI) &&
                              inst.i.imm == `CPU3_CSR_TOHOST;
            end
            default: ;
        endcase
        return c;
    endfunction

    assign x_ctrl  = decode(fd_x.inst);
    assign mw_ctrl = decode(mw_inst);

    // Branch resolution from compare flags
    always_comb begin
        case (x_inst.b.funct3)
            `CPU3_F3_BEQ:  take = br_eq;
            `CPU3_F3_BNE:  take = !br_eq;
            `CPU3_F3_BLT:  take = br_lt;
            `CPU3_F3_BGE:  take = !br_lt;
            `CPU3_F3_BLTU: take = br_ltu;
            `CPU3_F3_BGEU: take = !br_ltu;
            default:       take = 1'b0;
        endcase
    end

    assign branch_taken = (x_inst.b.opcode == `CPU3_OP_BRANCH) && take;

    // A taken branch leaves a bubble in X behind it
    assert property (@(posedge clk) disable iff (rst)
        branch_taken |=> x_inst == `CPU3_NOP);

endmodule

// File: hw/fetch_decode.sv
`timescale 1ns/10ps
`include "cpu3_defs.svh"

module fetch_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                prog_we,
    input  logic [$clog2(`CPU3_IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                         prog_data,
    input  logic                                branch_taken,
    input  logic [31:0]                         branch_target,
    input  cpu3_pkg::wb_t                       wb,
    input  logic [31:0]                         rd1,
    input  logic [31:0]                         rd2,
    output logic [4:0]                          ra1,
    output logic [4:0]                          ra2,
    output cpu3_pkg::fd_x_t                     fd_x
);
    import cpu3_pkg::*;

    localparam int IMEM_AW = $clog2(`CPU3_IMEM_WORDS);

    logic [31:0] imem [`CPU3_IMEM_WORDS];
    logic [31:0] imem_q;
    logic [31:0] pc_q;
    logic        fd_live;
    logic [31:0] next_pc;
    inst_u       inst_fd;
    logic [31:0] imm_fd;
    logic [31:0] rs1_fd;
    logic [31:0] rs2_fd;

    // pc_q is the PC of the word now in FD
    // Until the first fetch returns, re-issue the reset PC
    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else if (fd_live) begin
            next_pc = pc_q + 32'd4;
        end else begin
            next_pc = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= `CPU3_RESET_PC;
            fd_live <= 1'b0;
        end else begin
            pc_q    <= next_pc;
            fd_live <= 1'b1;
        end
    end

    // Instruction memory
    // Load port for the program, sync read addressed by next PC
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        imem_q <= imem[next_pc[IMEM_AW+1:2]];
    end

    // No valid fetch yet, so decode a bubble
    assign inst_fd = fd_live ? imem_q : `CPU3_NOP;

    // Immediate generation
    always_comb begin
        case (inst_fd.r.opcode)
            `CPU3_OP_STORE:
                imm_fd = {{20{inst_fd.s.imm_hi[6]}}, inst_fd.s.imm_hi, inst_fd.s.imm_lo};
            `CPU3_OP_BRANCH:
                imm_fd = {{20{inst_fd.b.imm_12}}, inst_fd.b.imm_11, inst_fd.b.imm_10_5,
                          inst_fd.b.imm_4_1, 1'b0};
            `CPU3_OP_LUI, `CPU3_OP_AUIPC:
                imm_fd = {inst_fd.u.imm, 12'b0};
            // I-type: OP-IMM, loads, CSR number
            default:
                imm_fd = {{20{inst_fd.i.imm[11]}}, inst_fd.i.imm};
        endcase
    end

    assign ra1 = inst_fd.r.rs1;
    assign ra2 = inst_fd.r.rs2;

    // Writeback lands this same cycle, so take it directly
    // wen is never set for x0
    assign rs1_fd = (wb.wen && wb.rd == ra1) ? wb.data : rd1;
    assign rs2_fd = (wb.wen && wb.rd == ra2) ? wb.data : rd2;

    // FD-to-X register
    // A taken branch in X kills the wrong-path word in FD
    always_ff @(posedge clk) begin
        if (rst || branch_taken) begin
            fd_x.inst <= `CPU3_NOP;
        end else begin
            fd_x.inst <= inst_fd;
        end
        fd_x.pc      <= pc_q;
        fd_x.imm     <= imm_fd;
        fd_x.rs1_val <= rs1_fd;
        fd_x.rs2_val <= rs2_fd;
    end

    // Program must only be loaded with the core held in reset
    assert property (@(posedge clk) prog_we |-> rst);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic          clk,
    input  logic          rst,
    input  logic [4:0]    ra1,
    input  logic [4:0]    ra2,
    input  cpu3_pkg::wb_t wb,
    output logic [31:0]   rd1,
    output logic [31:0]   rd2
);
    // x0 has no storage
    logic [31:0] regs [1:31];

    // Write at end of MW; wen already excludes x0
    always_ff @(posedge clk) begin
        if (wb.wen && !rst) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Async reads
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: hw/cpu3_pkg.sv
package cpu3_pkg;

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate, load and CSR format
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Store format, immediate split around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch format, scrambled immediate bits
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // Upper immediate format
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, read through whichever view fits
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
    } alu_op_e;

    // Per-instruction control
    typedef struct packed {
        logic    a_sel_pc;
        logic    b_sel_imm;
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    reg_wen;
        logic    wb_sel_mem;
        logic    csr_write;
    } ctrl_t;

    // FD-to-X register
    typedef struct packed {
        logic [31:0] pc;
        inst_u       inst;
        logic [31:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } fd_x_t;

    // X-to-MW register
    typedef struct packed {
        inst_u       inst;
        logic [31:0] alu;
    } x_mw_t;

    // Writeback, fans out to regfile and both bypass points
    typedef struct packed {
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// File: hw/cpu3_defs.svh
`ifndef CPU3_DEFS_SVH
`define CPU3_DEFS_SVH

// First fetch address after reset
`define CPU3_RESET_PC 32'h0000_0000

// On-chip memory depths, in 32-bit words
`define CPU3_IMEM_WORDS 1024
`define CPU3_DMEM_WORDS 1024

// Major opcodes, bits 6:0
`define CPU3_OP_LUI    7'b0110111
`define CPU3_OP_AUIPC  7'b0010111
`define CPU3_OP_IMM    7'b0010011
`define CPU3_OP_REG    7'b0110011
`define CPU3_OP_LOAD   7'b0000011
`define CPU3_OP_STORE  7'b0100011
`define CPU3_OP_BRANCH 7'b1100011
`define CPU3_OP_SYSTEM 7'b1110011

// ALU funct3
`define CPU3_F3_ADD  3'b000
`define CPU3_F3_SLL  3'b001
`define CPU3_F3_SLT  3'b010
`define CPU3_F3_SLTU 3'b011
`define CPU3_F3_XOR  3'b100
`define CPU3_F3_SR   3'b101
`define CPU3_F3_OR   3'b110
`define CPU3_F3_AND  3'b111

// Branch funct3
`define CPU3_F3_BEQ  3'b000
`define CPU3_F3_BNE  3'b001
`define CPU3_F3_BLT  3'b100
`define CPU3_F3_BGE  3'b101
`define CPU3_F3_BLTU 3'b110
`define CPU3_F3_BGEU 3'b111

// Load and store width funct3
`define CPU3_F3_B  3'b000
`define CPU3_F3_H  3'b001
`define CPU3_F3_W  3'b010
`define CPU3_F3_BU 3'b100
`define CPU3_F3_HU 3'b101

// CSR access
`define CPU3_F3_CSRRW  3'b001
`define CPU3_F3_CSRRWI 3'b101
`define CPU3_CSR_TOHOST 12'h51E

// ADDI x0, x0, 0
`define CPU3_NOP 32'h0000_0013

`endif
